/* hw/video_out_pkg.sv */
`default_nettype none

package video_out_pkg;

  // Bus and pixel widths
  localparam int COLOR_W    = 8;
  localparam int HDMI_W     = 16;
  localparam int STREAM_W   = 32;
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  //////////////////////////////////////////////////
  // Raster, shrunk to a test size
  //////////////////////////////////////////////////
  localparam int H_CNT_W = 5;
  localparam int V_CNT_W = 3;

  localparam logic [H_CNT_W-1:0] H_ACTIVE = 5'd16;
  localparam logic [H_CNT_W-1:0] H_TOTAL  = 5'd24;
  localparam logic [H_CNT_W-1:0] HS_START = 5'd18;
  localparam logic [H_CNT_W-1:0] HS_END   = 5'd20;
  localparam logic [V_CNT_W-1:0] V_ACTIVE = 3'd4;
  localparam logic [V_CNT_W-1:0] V_TOTAL  = 3'd6;
  // Vsync covers this whole line
  localparam logic [V_CNT_W-1:0] VS_LINE  = 3'd5;

  // Register map
  localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_FRAMES    = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_UNDERRUNS = 8'h08;

  //////////////////////////////////////////////////
  // Colour constants
  //////////////////////////////////////////////////
  localparam logic [COLOR_W-1:0] Y_BLACK = 8'd16;
  localparam logic [COLOR_W-1:0] C_BLACK = 8'd128;

  // BT.601 coefficients, scaled by 2^FRAC_W
  localparam int PROD_W = 18;
  localparam int FRAC_W = 8;
  localparam logic signed [PROD_W-1:0] Y_R_COEF  = 18'sd66;
  localparam logic signed [PROD_W-1:0] Y_G_COEF  = 18'sd129;
  localparam logic signed [PROD_W-1:0] Y_B_COEF  = 18'sd25;
  localparam logic signed [PROD_W-1:0] CB_R_COEF = -18'sd38;
  localparam logic signed [PROD_W-1:0] CB_G_COEF = -18'sd74;
  localparam logic signed [PROD_W-1:0] CB_B_COEF = 18'sd112;
  localparam logic signed [PROD_W-1:0] CR_R_COEF = 18'sd112;
  localparam logic signed [PROD_W-1:0] CR_G_COEF = -18'sd94;
  localparam logic signed [PROD_W-1:0] CR_B_COEF = -18'sd18;
  localparam logic signed [PROD_W-1:0] ROUND_C   = 18'sd128;

  // Pixel request to HDMI word, in cycles
  localparam int PIPE_LAT = 4;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  typedef struct packed {
    logic [COLOR_W-1:0] y;
    logic [COLOR_W-1:0] cb;
    logic [COLOR_W-1:0] cr;
  } ycbcr_t;

endpackage

`default_nettype wire

/* hw/video_apb_regs.sv */
`default_nettype none

module video_apb_regs (
  input  logic                                 video_clk_148,
  input  logic                                 video_reset_148,
  input  logic [video_out_pkg::APB_ADDR_W-1:0] i_paddr,
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [video_out_pkg::APB_DATA_W-1:0] i_pwdata,
  output logic [video_out_pkg::APB_DATA_W-1:0] o_prdata,
  output logic                                 o_pready,
  output logic                                 o_pslverr,
  input  logic                                 i_frame_start,
  input  logic                                 i_underrun,
  output logic                                 o_enable
);

  import video_out_pkg::*;

  logic                  access;
  logic                  mapped;
  logic [APB_DATA_W-1:0] rd_mux;
  logic [APB_DATA_W-1:0] frame_cnt;
  logic [APB_DATA_W-1:0] underrun_cnt;

  // Access phase only, no wait states
  assign access   = i_psel && i_penable;
  assign o_pready = 1'b1;

  always_comb
  begin
    mapped = 1'b1;
    rd_mux = '0;
    case (i_paddr)
      REG_CTRL:      rd_mux = {{(APB_DATA_W-1){1'b0}}, o_enable};
      REG_FRAMES:    rd_mux = frame_cnt;
      REG_UNDERRUNS: rd_mux = underrun_cnt;
      default:       mapped = 1'b0;
    endcase
  end

  assign o_prdata  = (access && !i_pwrite) ? rd_mux : '0;
  assign o_pslverr = access && !mapped;

  //////////////////////////////////////////////////
  // Control register
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      o_enable <= 1'b0;
    end
    else if (access && i_pwrite && i_paddr == REG_CTRL)
    begin
      o_enable <= i_pwdata[0];
    end
  end

  // Event counters, read only
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      frame_cnt    <= '0;
      underrun_cnt <= '0;
    end
    else
    begin
      if (i_frame_start)
        frame_cnt <= frame_cnt + 1'b1;
      if (i_underrun)
        underrun_cnt <= underrun_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/video_timing_gen.sv */
`default_nettype none

module video_timing_gen (
  input  logic video_clk_148,
  input  logic video_reset_148,
  input  logic i_enable,
  output logic o_de,
  output logic o_hsync,
  output logic o_vsync,
  output logic o_frame_start
);

  import video_out_pkg::*;

  logic [H_CNT_W-1:0] h_cnt;
  logic [V_CNT_W-1:0] v_cnt;
  logic               h_last;
  logic               v_last;

  assign h_last = (h_cnt == H_TOTAL - 1'b1);
  assign v_last = (v_cnt == V_TOTAL - 1'b1);

  //////////////////////////////////////////////////
  // Pixel and line counters
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148 || !i_enable)
    begin
      // Parked at the top left corner
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (h_last)
    begin
      h_cnt <= '0;
      if (v_last)
        v_cnt <= '0;
      else
        v_cnt <= v_cnt + 1'b1;
    end
    else
    begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Registered raster outputs
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      o_de          <= 1'b0;
      o_hsync       <= 1'b0;
      o_vsync       <= 1'b0;
      o_frame_start <= 1'b0;
    end
    else
    begin
      o_de    <= i_enable && (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
      o_hsync <= i_enable && (h_cnt >= HS_START) && (h_cnt < HS_END);
      o_vsync <= i_enable && (v_cnt == VS_LINE);
      // Wrap back to line 0, so the start after enable is not counted
      o_frame_start <= i_enable && h_last && v_last;
    end
  end

endmodule

`default_nettype wire

/* hw/rgb_to_ycbcr.sv */
`default_nettype none

module rgb_to_ycbcr (
  input  logic                  video_clk_148,
  input  logic                  video_reset_148,
  input  logic                  i_de,
  input  video_out_pkg::rgb_t   i_rgb,
  output logic                  o_de,
  output video_out_pkg::ycbcr_t o_ycbcr
);

  import video_out_pkg::*;

  logic signed [PROD_W-1:0] r_ext, g_ext, b_ext;
  logic signed [PROD_W-1:0] y_r, y_g, y_b;
  logic signed [PROD_W-1:0] cb_r, cb_g, cb_b;
  logic signed [PROD_W-1:0] cr_r, cr_g, cr_b;
  logic signed [PROD_W-1:0] y_sum, cb_sum, cr_sum;
  logic signed [PROD_W-1:0] y_shift, cb_shift, cr_shift;
  logic                     de_s1, de_s2;

  // Components are unsigned, widen before the signed multiply
  assign r_ext = signed'(PROD_W'(i_rgb.r));
  assign g_ext = signed'(PROD_W'(i_rgb.g));
  assign b_ext = signed'(PROD_W'(i_rgb.b));

  //////////////////////////////////////////////////
  // Stage 1, products
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    y_r  <= r_ext * Y_R_COEF;
    y_g  <= g_ext * Y_G_COEF;
    y_b  <= b_ext * Y_B_COEF;
    cb_r <= r_ext * CB_R_COEF;
    cb_g <= g_ext * CB_G_COEF;
    cb_b <= b_ext * CB_B_COEF;
    cr_r <= r_ext * CR_R_COEF;
    cr_g <= g_ext * CR_G_COEF;
    cr_b <= b_ext * CR_B_COEF;
  end

  // Stage 2, sums with rounding
  always_ff @(posedge video_clk_148)
  begin
    y_sum  <= y_r + y_g + y_b + ROUND_C;
    cb_sum <= cb_r + cb_g + cb_b + ROUND_C;
    cr_sum <= cr_r + cr_g + cr_b + ROUND_C;
  end

  // Chroma sums can go negative
  assign y_shift  = y_sum >>> FRAC_W;
  assign cb_shift = cb_sum >>> FRAC_W;
  assign cr_shift = cr_sum >>> FRAC_W;

  // Stage 3, scale down and add offsets
  always_ff @(posedge video_clk_148)
  begin
    o_ycbcr.y  <= y_shift[COLOR_W-1:0] + Y_BLACK;
    o_ycbcr.cb <= cb_shift[COLOR_W-1:0] + C_BLACK;
    o_ycbcr.cr <= cr_shift[COLOR_W-1:0] + C_BLACK;
  end

  // Data enable follows the three stages
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      de_s1 <= 1'b0;
      de_s2 <= 1'b0;
      o_de  <= 1'b0;
    end
    else
    begin
      de_s1 <= i_de;
      de_s2 <= de_s1;
      o_de  <= de_s2;
    end
  end

endmodule

`default_nettype wire

/* hw/ycbcr_422_packer.sv */
`default_nettype none

module ycbcr_422_packer (
  input  logic                             video_clk_148,
  input  logic                             video_reset_148,
  input  logic                             i_de,
  input  video_out_pkg::ycbcr_t            i_ycbcr,
  input  logic                             i_hsync,
  input  logic                             i_vsync,
  output logic                             o_de,
  output logic                             o_hsync,
  output logic                             o_vsync,
  output logic [video_out_pkg::HDMI_W-1:0] o_txd
);

  import video_out_pkg::*;

  logic                phase;
  logic [COLOR_W-1:0]  chroma;
  logic [PIPE_LAT-1:0] hs_dly;
  logic [PIPE_LAT-1:0] vs_dly;

  // Cb on even pixels, Cr on odd ones
  assign chroma = phase ? i_ycbcr.cr : i_ycbcr.cb;

  //////////////////////////////////////////////////
  // 4:2:2 word
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      phase <= 1'b0;
      o_de  <= 1'b0;
      o_txd <= '0;
    end
    else
    begin
      // Restart at Cb on every line
      phase <= i_de ? ~phase : 1'b0;
      o_de  <= i_de;
      o_txd <= i_de ? {chroma, i_ycbcr.y} : '0;
    end
  end

  // Syncs skip the converter, so delay them by the full latency
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      hs_dly <= '0;
      vs_dly <= '0;
    end
    else
    begin
      hs_dly <= {hs_dly[PIPE_LAT-2:0], i_hsync};
      vs_dly <= {vs_dly[PIPE_LAT-2:0], i_vsync};
    end
  end

  assign o_hsync = hs_dly[PIPE_LAT-1];
  assign o_vsync = vs_dly[PIPE_LAT-1];

endmodule

`default_nettype wire

/* hw/hdmi_yuv_out_top.sv */
`default_nettype none

module hdmi_yuv_out_top (
  input  logic                                 video_clk_148,
  input  logic                                 video_reset_148,
  // Pixel stream
  input  logic                                 i_pix_valid,
  input  logic [video_out_pkg::STREAM_W-1:0]   i_pix_data,
  output logic                                 o_pix_ready,
  // APB
  input  logic [video_out_pkg::APB_ADDR_W-1:0] i_paddr,
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [video_out_pkg::APB_DATA_W-1:0] i_pwdata,
  output logic [video_out_pkg::APB_DATA_W-1:0] o_prdata,
  output logic                                 o_pready,
  output logic                                 o_pslverr,
  // HDMI
  output logic                                 o_hdmi_de,
  output logic                                 o_hdmi_hsync,
  output logic                                 o_hdmi_vsync,
  output logic [video_out_pkg::HDMI_W-1:0]     o_hdmi_txd
);

  import video_out_pkg::*;

  logic   enable;
  logic   frame_start;
  logic   tg_de, tg_hsync, tg_vsync;
  logic   take;
  logic   underrun;
  rgb_t   pix_sel;
  logic   cv_de;
  ycbcr_t cv_ycbcr;

  //////////////////////////////////////////////////
  // Stream handshake
  //////////////////////////////////////////////////
  assign o_pix_ready = tg_de;
  assign take        = tg_de && i_pix_valid;
  // Requested but nothing offered
  assign underrun    = tg_de && !i_pix_valid;
  assign pix_sel     = take ? rgb_t'(i_pix_data[3*COLOR_W-1:0]) : '0;

  video_apb_regs u_regs (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_paddr         (i_paddr),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_pwdata        (i_pwdata),
    .o_prdata        (o_prdata),
    .o_pready        (o_pready),
    .o_pslverr       (o_pslverr),
    .i_frame_start   (frame_start),
    .i_underrun      (underrun),
    .o_enable        (enable)
  );

  video_timing_gen u_timing (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_enable        (enable),
    .o_de            (tg_de),
    .o_hsync         (tg_hsync),
    .o_vsync         (tg_vsync),
    .o_frame_start   (frame_start)
  );

  rgb_to_ycbcr u_csc (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_de            (tg_de),
    .i_rgb           (pix_sel),
    .o_de            (cv_de),
    .o_ycbcr         (cv_ycbcr)
  );

  ycbcr_422_packer u_packer (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_de            (cv_de),
    .i_ycbcr         (cv_ycbcr),
    .i_hsync         (tg_hsync),
    .i_vsync         (tg_vsync),
    .o_de            (o_hdmi_de),
    .o_hsync         (o_hdmi_hsync),
    .o_vsync         (o_hdmi_vsync),
    .o_txd           (o_hdmi_txd)
  );

endmodule

`default_nettype wire

/* verification/hdmi_yuv_out_sva.sv */
`default_nettype none

module hdmi_yuv_out_sva (
  input wire logic video_clk_148,
  input wire logic video_reset_148,
  input wire logic i_enable,
  input wire logic i_pix_ready,
  input wire logic i_hdmi_de,
  input wire logic i_hdmi_hsync,
  input wire logic i_hdmi_vsync
);

  // Ready is registered, so it trails the enable bit by one cycle
  ready_needs_enable: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148)
    i_pix_ready |-> $past(i_enable)
  ) else $error("pixel request while output disabled");

  // Two cycles of hsync per line
  hsync_width: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148 || !i_enable)
    $fell(i_hdmi_hsync) |-> $past(i_hdmi_hsync, 2) && !$past(i_hdmi_hsync, 3)
  ) else $error("hsync width is not two cycles");

  // Vsync spans one full line of 24 cycles
  vsync_width: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148 || !i_enable)
    $fell(i_hdmi_vsync) |-> $past(i_hdmi_vsync, 24) && !$past(i_hdmi_vsync, 25)
  ) else $error("vsync width is not one line");

  de_outside_hsync: assert property (
    @(posedge video_clk_148) disable iff (video_reset_148)
    !(i_hdmi_de && i_hdmi_hsync)
  ) else $error("data enable high during hsync");

endmodule

bind hdmi_yuv_out_top hdmi_yuv_out_sva u_sva (
  .video_clk_148   (video_clk_148),
  .video_reset_148 (video_reset_148),
  .i_enable        (enable),
  .i_pix_ready     (o_pix_ready),
  .i_hdmi_de       (o_hdmi_de),
  .i_hdmi_hsync    (o_hdmi_hsync),
  .i_hdmi_vsync    (o_hdmi_vsync)
);

`default_nettype wire

/* verification/hdmi_yuv_out_tb.sv */
`default_nettype none

module hdmi_yuv_out_tb;

  import video_out_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_VEC    = 16;
  localparam int FRAME_CYC  = int'(H_TOTAL) * int'(V_TOTAL);
  localparam int WATCHDOG   = (16 + 10 * FRAME_CYC + 200) * CLK_PERIOD;
  localparam int SRC_IDLE   = 0;
  localparam int SRC_ALWAYS = 1;
  localparam int SRC_GAPS   = 2;
  localparam int SRC_HOLD   = 3;

  logic                  video_clk_148;
  logic                  video_reset_148;
  logic                  i_pix_valid;
  logic [STREAM_W-1:0]   i_pix_data;
  logic                  o_pix_ready;
  logic [APB_ADDR_W-1:0] i_paddr;
  logic                  i_psel;
  logic                  i_penable;
  logic                  i_pwrite;
  logic [APB_DATA_W-1:0] i_pwdata;
  logic [APB_DATA_W-1:0] o_prdata;
  logic                  o_pready;
  logic                  o_pslverr;
  logic                  o_hdmi_de;
  logic                  o_hdmi_hsync;
  logic                  o_hdmi_vsync;
  logic [HDMI_W-1:0]     o_hdmi_txd;

  logic [47:0]   vectors [NUM_VEC];
  logic [15:0]   exp_q[$];
  logic [3:0]    ready_hist;
  logic [31:0]   lfsr;
  string         test_name;
  int            src_mode;
  int            src_idx;
  int            line_pos;
  int            takes;
  int            misses;
  int            words_checked;
  int            err_count;
  int            test_err_base;
  int            tests_passed;
  int            tests_failed;

  hdmi_yuv_out_top uut (.*);

  always #(CLK_PERIOD / 2) video_clk_148 = ~video_clk_148;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, got);
      err_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond)
    else
    begin
      $display("Test %s failed: %s", test_name, msg);
      err_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////
  task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
    @(negedge video_clk_148);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge video_clk_148);
    i_penable = 1'b1;
    // Middle of the low phase, well clear of the edge
    #(CLK_PERIOD / 4);
    check_true(o_pready, "PREADY low in access phase");
    rdata = o_prdata;
    err   = o_pslverr;
    @(negedge video_clk_148);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_value("write PSLVERR", 32'd0, 32'(err));
  endtask

  task automatic reg_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_value("read PSLVERR", 32'd0, 32'(err));
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_err_base)
    begin
      tests_passed++;
      $display("Test %s: passed", test_name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", test_name, err_count - test_err_base);
    end
  endtask

  //////////////////////////////////////////////////
  // Stream source and scoreboard
  //////////////////////////////////////////////////
  always @(negedge video_clk_148)
  begin : stream_side
    logic [47:0] v;
    logic [7:0]  ey;
    logic [7:0]  ec;
    logic [15:0] exp_w;
    logic        bit_a;
    logic        bit_b;
    logic        valid_nx;
    if (!video_reset_148)
    begin
      // Output word belongs to the request four cycles back
      check_true(o_hdmi_de == ready_hist[3], "data enable does not follow pixel requests");
      if (o_hdmi_de)
      begin
        if (exp_q.size() == 0)
        begin
          check_true(1'b0, "HDMI word with no pixel requested");
        end
        else
        begin
          exp_w = exp_q.pop_front();
          check_value("hdmi word", 32'(exp_w), 32'(o_hdmi_txd));
          words_checked++;
        end
      end
      ready_hist = {ready_hist[2:0], o_pix_ready};
      case (src_mode)
        SRC_ALWAYS, SRC_HOLD: valid_nx = 1'b1;
        SRC_GAPS:
        begin
          lfsr     = lfsr_next(lfsr);
          bit_a    = lfsr[0];
          lfsr     = lfsr_next(lfsr);
          bit_b    = lfsr[0];
          valid_nx = bit_a | bit_b;
        end
        default: valid_nx = 1'b0;
      endcase
      // Sampled at the next rising edge together with this ready
      i_pix_valid = valid_nx;
      i_pix_data  = {8'h00, vectors[src_idx][47:24]};
      if (o_pix_ready)
      begin
        if (valid_nx)
        begin
          v       = vectors[src_idx];
          ey      = v[23:16];
          ec      = (line_pos % 2 == 1) ? v[7:0] : v[15:8];
          src_idx = (src_idx + 1) % NUM_VEC;
          takes++;
        end
        else
        begin
          ey = Y_BLACK;
          ec = C_BLACK;
          misses++;
        end
        exp_q.push_back({ec, ey});
        line_pos++;
      end
      else
      begin
        line_pos = 0;
      end
    end
  end

  // One output frame, starting where vsync falls
  task automatic measure_frame();
    logic prev_de;
    logic prev_hs;
    logic prev_vs;
    logic line_open;
    int   de_runs;
    int   de_len;
    int   hs_runs;
    int   hs_len;
    int   vs_len;
    int   line_first;
    int   guard;
    prev_de   = 1'b0;
    prev_hs   = 1'b0;
    line_open = 1'b0;
    de_runs   = 0;
    de_len    = 0;
    hs_runs   = 0;
    hs_len    = 0;
    vs_len    = 0;
    line_first = 0;
    guard     = 0;
    prev_vs   = 1'b0;
    while (!(prev_vs && !o_hdmi_vsync) && guard < 2 * FRAME_CYC)
    begin
      prev_vs = o_hdmi_vsync;
      @(negedge video_clk_148);
      guard++;
    end
    check_true(guard < 2 * FRAME_CYC, "no vsync seen within two frames");
    for (int c = 0; c < FRAME_CYC; c++)
    begin
      if (o_hdmi_de && !prev_de)
      begin
        de_runs++;
        de_len     = 0;
        line_first = c;
        line_open  = 1'b1;
      end
      if (o_hdmi_de)
        de_len++;
      if (!o_hdmi_de && prev_de)
        check_value("de run length", 32'(H_ACTIVE), 32'(de_len));
      if (o_hdmi_hsync && !prev_hs)
      begin
        hs_runs++;
        hs_len = 0;
        if (line_open)
          check_value("hsync offset", 32'(HS_START), 32'(c - line_first));
        line_open = 1'b0;
      end
      if (o_hdmi_hsync)
        hs_len++;
      if (!o_hdmi_hsync && prev_hs)
        check_value("hsync width", 32'(HS_END - HS_START), 32'(hs_len));
      if (o_hdmi_vsync)
        vs_len++;
      prev_de = o_hdmi_de;
      prev_hs = o_hdmi_hsync;
      @(negedge video_clk_148);
    end
    check_value("active lines", 32'(V_ACTIVE), 32'(de_runs));
    check_value("hsync count", 32'(V_TOTAL), 32'(hs_runs));
    check_value("vsync length", 32'(H_TOTAL), 32'(vs_len));
  endtask

  initial
  begin : run_sequence
    logic [31:0] rd;
    logic [31:0] f0;
    logic        err;
    int          takes_base;
    video_clk_148   = 1'b0;
    video_reset_148 = 1'b1;
    i_pix_valid     = 1'b0;
    i_pix_data      = '0;
    i_paddr         = '0;
    i_psel          = 1'b0;
    i_penable       = 1'b0;
    i_pwrite        = 1'b0;
    i_pwdata        = '0;
    ready_hist      = '0;
    lfsr            = 32'he31d_450d;
    src_mode        = SRC_IDLE;
    src_idx         = 0;
    line_pos        = 0;
    takes           = 0;
    misses          = 0;
    words_checked   = 0;
    err_count       = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    $readmemh("verification/hdmi_yuv_out_vectors.txt", vectors);
    repeat (16) @(negedge video_clk_148);
    video_reset_148 = 1'b0;

    start_test("reset_and_registers");
    check_value("o_pix_ready", 32'd0, 32'(o_pix_ready));
    check_value("o_hdmi_de", 32'd0, 32'(o_hdmi_de));
    check_value("o_hdmi_hsync", 32'd0, 32'(o_hdmi_hsync));
    check_value("o_hdmi_vsync", 32'd0, 32'(o_hdmi_vsync));
    check_value("o_hdmi_txd", 32'd0, 32'(o_hdmi_txd));
    check_value("o_pslverr", 32'd0, 32'(o_pslverr));
    reg_read(REG_CTRL, rd);
    check_value("REG_CTRL", 32'd0, rd);
    reg_read(REG_FRAMES, rd);
    check_value("REG_FRAMES", 32'd0, rd);
    reg_read(REG_UNDERRUNS, rd);
    check_value("REG_UNDERRUNS", 32'd0, rd);
    apb_access(1'b0, 8'h0c, '0, rd, err);
    check_value("unmapped PSLVERR", 32'd1, 32'(err));
    check_value("unmapped data", 32'd0, rd);
    end_test();

    start_test("pixel_stream");
    @(posedge video_clk_148);
    src_mode = SRC_ALWAYS;
    reg_write(REG_CTRL, 32'd1);
    repeat (2 * FRAME_CYC) @(posedge video_clk_148);
    check_true(words_checked >= 2 * int'(V_ACTIVE) * int'(H_ACTIVE),
               "too few HDMI words seen");
    reg_read(REG_UNDERRUNS, rd);
    check_value("REG_UNDERRUNS", 32'd0, rd);
    end_test();

    start_test("sync_timing");
    measure_frame();
    // Reads exactly three frames apart
    reg_read(REG_FRAMES, f0);
    repeat (3 * FRAME_CYC - 3) @(negedge video_clk_148);
    reg_read(REG_FRAMES, rd);
    check_value("REG_FRAMES delta", 32'd3, rd - f0);
    end_test();

    start_test("underrun_gaps");
    @(posedge video_clk_148);
    src_mode = SRC_GAPS;
    repeat (2 * FRAME_CYC) @(posedge video_clk_148);
    src_mode = SRC_ALWAYS;
    repeat (4) @(posedge video_clk_148);
    check_true(misses > 0, "random gaps produced no underrun");
    reg_read(REG_UNDERRUNS, rd);
    check_value("REG_UNDERRUNS", 32'(misses), rd);
    end_test();

    start_test("disable");
    reg_write(REG_CTRL, 32'd0);
    repeat (8) @(negedge video_clk_148);
    check_value("o_pix_ready", 32'd0, 32'(o_pix_ready));
    check_value("o_hdmi_hsync", 32'd0, 32'(o_hdmi_hsync));
    check_value("o_hdmi_vsync", 32'd0, 32'(o_hdmi_vsync));
    @(posedge video_clk_148);
    src_mode   = SRC_HOLD;
    takes_base = takes;
    reg_read(REG_FRAMES, f0);
    reg_write(REG_FRAMES, 32'h55);
    repeat (2 * FRAME_CYC) @(negedge video_clk_148);
    check_value("takes while disabled", 32'(takes_base), 32'(takes));
    check_value("o_pix_ready", 32'd0, 32'(o_pix_ready));
    reg_read(REG_FRAMES, rd);
    check_value("REG_FRAMES", f0, rd);
    check_true(exp_q.size() == 0, "pixels still pending after disable");
    end_test();

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin : watchdog
    #(WATCHDOG);
    $display("Watchdog expired: the run took longer than ten frames plus margin");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/hdmi_yuv_out_vectors.txt */
// Columns: RGB pixel, expected Y, expected Cb, expected Cr (hex)
// Layout per word: rrggbb_yy_cb_cr
000000_10_80_80
ffffff_eb_80_80
ff0000_52_5a_f0
00ff00_90_36_22
0000ff_29_f0_6e
808080_7e_80_80
ffff00_d2_10_92
00ffff_a9_a6_10
ff00ff_6b_ca_de
102030_29_89_78
404040_47_80_80
c0c0c0_b5_80_80
800000_31_6d_b8
008000_51_5b_51
000080_1d_b8_77
010203_12_81_7f

/* filelist.f */
hw/video_out_pkg.sv
hw/video_apb_regs.sv
hw/video_timing_gen.sv
hw/rgb_to_ycbcr.sv
hw/ycbcr_422_packer.sv
hw/hdmi_yuv_out_top.sv
verification/hdmi_yuv_out_sva.sv
verification/hdmi_yuv_out_tb.sv

/* Makefile */
TOP = hdmi_yuv_out_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
